// ==== src/noise_consts.svh ====
`ifndef NOISE_CONSTS_SVH
`define NOISE_CONSTS_SVH

// Clock cycles per frame sequencer step
// Any value of 2 or more works
// Small values make short simulations
`define FS_STEP_CYCLES 16

// Full range of the length counter
`define LEN_MAX 64

// Noise shift register width
`define LFSR_W 15

`endif

// ==== src/noise_pkg.sv ====
package noise_pkg;

	// ff21 layout
	typedef struct packed {
		logic [3:0] vol_init;   // Starting volume
		logic       env_up;     // Envelope direction
		logic [2:0] env_period; // Envelope ticks per step where 0 stops
	} env_cfg_t;

	// ff22 layout
	typedef struct packed {
		logic [3:0] clk_shift;  // Timer shift where 14 and 15 stop the LFSR
		logic       narrow;     // Seven bit mode
		logic [2:0] div_code;   // Timer base divisor
	} poly_cfg_t;

	// One cycle pulses from the frame sequencer
	typedef struct packed {
		logic len_tick;         // Even steps
		logic env_tick;         // Step 7
	} fs_ticks_t;

endpackage

// ==== src/ch4_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module ch4_regs (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [1:0]           reg_sel,
	input  logic                 wr,
	input  logic                 rd,
	input  logic [7:0]           wdata,
	output logic [7:0]           rdata,
	output noise_pkg::env_cfg_t  env_cfg,
	output noise_pkg::poly_cfg_t poly_cfg,
	output logic [5:0]           len_load,
	output logic                 len_load_wr,
	output logic                 len_en,
	output logic                 trigger
);
	import noise_pkg::*;

	logic       sel_ff20;
	logic       sel_ff21;
	logic       sel_ff22;
	logic       sel_ff23;
	logic [7:0] rd_mux;

	assign sel_ff20 = (reg_sel == 2'd0);
	assign sel_ff21 = (reg_sel == 2'd1);
	assign sel_ff22 = (reg_sel == 2'd2);
	assign sel_ff23 = (reg_sel == 2'd3);

	// ff20 is write only and goes straight to the length counter
	assign len_load_wr = wr && sel_ff20;
	assign len_load    = wdata[5:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			env_cfg  <= '0;
			poly_cfg <= '0;
			len_en   <= 1'b0;
		end else if (wr) begin
			if (sel_ff21)
				env_cfg <= env_cfg_t'(wdata);
			if (sel_ff22)
				poly_cfg <= poly_cfg_t'(wdata);
			if (sel_ff23)
				len_en <= wdata[6]; // Length enable
		end
	end

	// Bit 7 of ff23 only restarts the channel and is not stored
	always_ff @(posedge clk) begin
		if (!rst_n)
			trigger <= 1'b0;
		else
			trigger <= wr && sel_ff23 && wdata[7];
	end

	always_comb begin
		case (reg_sel)
			2'd0:    rd_mux = 8'hff;                   // Length is write only
			2'd1:    rd_mux = env_cfg;
			2'd2:    rd_mux = poly_cfg;
			default: rd_mux = {1'b1, len_en, 6'h3f};
		endcase
	end

	// Read data holds until the next read
	always_ff @(posedge clk) begin
		if (!rst_n)
			rdata <= 8'h00;
		else if (rd)
			rdata <= rd_mux;
	end

endmodule

`default_nettype wire

// ==== src/frame_seq.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "noise_consts.svh"

module frame_seq (
	input  logic                 clk,
	input  logic                 rst_n,
	output noise_pkg::fs_ticks_t ticks
);
	localparam int PRE_W = $clog2(`FS_STEP_CYCLES);
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`FS_STEP_CYCLES - 1);

	logic [PRE_W-1:0] pre_cnt;
	logic [2:0]       step;
	logic [2:0]       step_nxt;
	logic             step_wrap;

	assign step_wrap = (pre_cnt == PRE_LAST);
	assign step_nxt  = step + 3'd1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pre_cnt <= '0;
			step    <= 3'd0;
			ticks   <= '0;
		end else begin
			ticks <= '0;
			if (step_wrap) begin
				pre_cnt        <= '0;
				step           <= step_nxt;
				ticks.len_tick <= ~step_nxt[0];      // 256 Hz role
				ticks.env_tick <= (step_nxt == 3'd7); // 64 Hz role
			end else begin
				pre_cnt <= pre_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/ch4_length.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "noise_consts.svh"

module ch4_length (
	input  logic                 clk,
	input  logic                 rst_n,
	input  noise_pkg::fs_ticks_t ticks,
	input  logic [5:0]           len_load,
	input  logic                 len_load_wr,
	input  logic                 len_en,
	input  logic                 trigger,
	input  logic                 dac_on,
	output logic                 active
);
	localparam logic [6:0] LEN_FULL = 7'(`LEN_MAX);

	logic [6:0] len_cnt;
	logic       len_dec;
	logic       len_expire;

	// A tick is dropped in a trigger or load cycle
	assign len_dec    = ticks.len_tick && len_en && (len_cnt != 7'd0) &&
	                    !len_load_wr && !trigger;
	assign len_expire = len_dec && (len_cnt == 7'd1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			len_cnt <= 7'd0;
			active  <= 1'b0;
		end else begin
			if (len_load_wr)
				len_cnt <= LEN_FULL - {1'b0, len_load};
			else if (trigger && (len_cnt == 7'd0))
				len_cnt <= LEN_FULL; // Expired counter restarts at full length
			else if (len_dec)
				len_cnt <= len_cnt - 7'd1;

			if (!dac_on)
				active <= 1'b0;
			else if (trigger)
				active <= 1'b1;
			else if (len_expire)
				active <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== src/ch4_noise.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "noise_consts.svh"

module ch4_noise (
	input  logic                 clk,
	input  logic                 rst_n,
	input  noise_pkg::poly_cfg_t poly_cfg,
	input  logic                 trigger,
	output logic                 noise_bit
);
	localparam int TMR_W = 20; // Holds 112 << 13

	logic [6:0]         div_base;
	logic [TMR_W-1:0]   tmr_reload;
	logic [TMR_W-1:0]   tmr;
	logic               stalled;
	logic               lfsr_step;
	logic               fb;
	logic [`LFSR_W-1:0] lfsr;
	logic [`LFSR_W-1:0] lfsr_nxt;

	assign div_base   = (poly_cfg.div_code == 3'd0) ? 7'd8 : {poly_cfg.div_code, 4'b0000};
	assign tmr_reload = TMR_W'(div_base) << poly_cfg.clk_shift;
	assign stalled    = (poly_cfg.clk_shift >= 4'd14);
	assign lfsr_step  = !stalled && (tmr == TMR_W'(1));

	assign fb = lfsr[0] ^ lfsr[1];

	always_comb begin
		lfsr_nxt = {fb, lfsr[`LFSR_W-1:1]};
		if (poly_cfg.narrow)
			lfsr_nxt[6] = fb; // Seven bit mode feeds back here too
	end

	// Timer sits idle at 0 until the first trigger
	always_ff @(posedge clk) begin
		if (!rst_n)
			tmr <= '0;
		else if (trigger)
			tmr <= tmr_reload;
		else if (!stalled && (tmr != '0)) begin
			if (tmr == TMR_W'(1))
				tmr <= tmr_reload;
			else
				tmr <= tmr - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			lfsr <= '1;
		else if (trigger)
			lfsr <= '1;
		else if (lfsr_step)
			lfsr <= lfsr_nxt;
	end

	assign noise_bit = ~lfsr[0];

endmodule

`default_nettype wire

// ==== src/ch4_volume.sv ====
`timescale 1ns/1ps
`default_nettype none

module ch4_volume (
	input  logic                 clk,
	input  logic                 rst_n,
	input  noise_pkg::fs_ticks_t ticks,
	input  noise_pkg::env_cfg_t  env_cfg,
	input  logic                 trigger,
	input  logic                 active,
	input  logic                 noise_bit,
	output logic                 dac_on,
	output logic [3:0]           sample
);
	logic [3:0] volume;
	logic [2:0] env_div;
	logic       env_run;
	logic       env_due;
	logic       at_limit;

	// DAC is off when both volume and direction bits are zero
	assign dac_on = (env_cfg.vol_init != 4'd0) || env_cfg.env_up;

	assign env_run  = ticks.env_tick && (env_cfg.env_period != 3'd0);
	assign env_due  = env_run && (env_div <= 3'd1);
	assign at_limit = env_cfg.env_up ? (volume == 4'd15) : (volume == 4'd0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			volume  <= 4'd0;
			env_div <= 3'd0;
		end else if (trigger) begin
			volume  <= env_cfg.vol_init;
			env_div <= env_cfg.env_period;
		end else if (env_due) begin
			env_div <= env_cfg.env_period;
			if (!at_limit) begin
				if (env_cfg.env_up)
					volume <= volume + 4'd1;
				else
					volume <= volume - 4'd1;
			end
		end else if (env_run) begin
			env_div <= env_div - 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			sample <= 4'd0;
		else if (active && noise_bit)
			sample <= volume;
		else
			sample <= 4'd0;
	end

endmodule

`default_nettype wire

// ==== src/ch4_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ch4_top (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [1:0] reg_sel,
	input  logic       wr,
	input  logic       rd,
	input  logic [7:0] wdata,
	output logic [7:0] rdata,
	output logic       active,
	output logic [3:0] sample
);
	import noise_pkg::*;

	env_cfg_t   env_cfg;
	poly_cfg_t  poly_cfg;
	fs_ticks_t  ticks;
	logic [5:0] len_load;
	logic       len_load_wr;
	logic       len_en;
	logic       trigger;
	logic       dac_on;
	logic       noise_bit;

	ch4_regs u_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.reg_sel     (reg_sel),
		.wr          (wr),
		.rd          (rd),
		.wdata       (wdata),
		.rdata       (rdata),
		.env_cfg     (env_cfg),
		.poly_cfg    (poly_cfg),
		.len_load    (len_load),
		.len_load_wr (len_load_wr),
		.len_en      (len_en),
		.trigger     (trigger)
	);

	frame_seq u_fs (
		.clk   (clk),
		.rst_n (rst_n),
		.ticks (ticks)
	);

	ch4_length u_length (
		.clk         (clk),
		.rst_n       (rst_n),
		.ticks       (ticks),
		.len_load    (len_load),
		.len_load_wr (len_load_wr),
		.len_en      (len_en),
		.trigger     (trigger),
		.dac_on      (dac_on),
		.active      (active)
	);

	ch4_noise u_noise (
		.clk       (clk),
		.rst_n     (rst_n),
		.poly_cfg  (poly_cfg),
		.trigger   (trigger),
		.noise_bit (noise_bit)
	);

	ch4_volume u_volume (
		.clk       (clk),
		.rst_n     (rst_n),
		.ticks     (ticks),
		.env_cfg   (env_cfg),
		.trigger   (trigger),
		.active    (active),
		.noise_bit (noise_bit),
		.dac_on    (dac_on),
		.sample    (sample)
	);

endmodule

`default_nettype wire

// ==== testbench/ch4_assert.sv ====
`timescale 1ns/1ps

module ch4_assert (
	input logic       clk,
	input logic       rst_n,
	input logic [7:0] rdata,
	input logic       active,
	input logic [3:0] sample,
	input logic       dac_on
);

	int errors = 0; // Failed assertion count

	// Sample trails active by one cycle
	property sample_needs_active;
		@(posedge clk) disable iff (!rst_n)
		(sample != 4'd0) |-> $past(active);
	endproperty

	property active_needs_dac;
		@(posedge clk) disable iff (!rst_n)
		$rose(active) |-> $past(dac_on);
	endproperty

	property rdata_clear_in_reset;
		@(posedge clk) !rst_n |=> (rdata == 8'h00);
	endproperty

	sample_chk: assert property (sample_needs_active)
		else begin
			$error("sample is nonzero while the channel was inactive");
			errors++;
		end
	dac_chk: assert property (active_needs_dac)
		else begin
			$error("active rose while the DAC was off");
			errors++;
		end
	rst_chk: assert property (rdata_clear_in_reset)
		else begin
			$error("rdata is not zero during reset");
			errors++;
		end

endmodule

bind ch4_top ch4_assert u_assert (
	.clk    (clk),
	.rst_n  (rst_n),
	.rdata  (rdata),
	.active (active),
	.sample (sample),
	.dac_on (dac_on)
);

// ==== testbench/ch4_tb.sv ====
`timescale 1ns/1ps
`include "noise_consts.svh"

module ch4_tb;
	import noise_pkg::*;

	localparam int FRAME     = 8 * `FS_STEP_CYCLES;
	localparam int LEN_CYC   = 8 * (`LEN_MAX * FRAME / 4 + 80); // Eight length runs
	localparam int NOISE_CYC = 6 * (64 * 448 + 20);             // Slowest timer is 448
	localparam int ENV_CYC   = 3 * ((16 * 7 + 2) * FRAME + 20);
	localparam int TOTAL_CYC = 400 + LEN_CYC + NOISE_CYC + ENV_CYC;
	localparam int MAX_CYC   = TOTAL_CYC + TOTAL_CYC / 4;

	logic       clk;
	logic       rst_n;
	logic [1:0] reg_sel;
	logic       wr;
	logic       rd;
	logic [7:0] wdata;
	logic [7:0] rdata;
	logic       active;
	logic [3:0] sample;

	integer seed;
	int     cycles = 0;
	int     passes = 0;
	int     fails = 0;
	int     test_fails = 0;

	// Reference model state
	env_cfg_t    m_env;
	poly_cfg_t   m_poly;
	fs_ticks_t   m_ticks;
	logic        m_len_en;
	logic        m_trig;
	logic        m_active;
	logic [7:0]  m_rdata;
	logic [14:0] m_lfsr;
	logic [3:0]  m_vol;
	logic [3:0]  m_sample;
	int          m_fs_cnt;
	int          m_step;
	int          m_len;
	int          m_tmr;
	int          m_div;
	int          m_steps;

	ch4_top UUT (
		.clk(clk), .rst_n(rst_n), .reg_sel(reg_sel), .wr(wr), .rd(rd),
		.wdata(wdata), .rdata(rdata), .active(active), .sample(sample)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYC) begin
			$display("Timeout after %0d cycles, the run did not finish", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	always @(posedge clk) begin : ref_model
		int          reload;
		int          step_n;
		logic        dac;
		logic        dec;
		logic        fb;
		logic [14:0] shifted;
		reload  = (m_poly.div_code == 3'd0) ? 8 : 16 * m_poly.div_code;
		reload  = (reload << m_poly.clk_shift) & 32'hfffff; // Timer is 20 bits wide
		step_n  = (m_step + 1) % 8;
		dac     = (m_env.vol_init != 4'd0) || m_env.env_up;
		dec     = m_ticks.len_tick && m_len_en && (m_len != 0) && !m_trig &&
		          !(wr && reg_sel == 2'd0);
		fb      = m_lfsr[0] ^ m_lfsr[1];
		shifted = {fb, m_lfsr[14:1]};
		if (m_poly.narrow)
			shifted[6] = fb;
		if (!rst_n) begin
			m_env    <= '0;
			m_poly   <= '0;
			m_ticks  <= '0;
			m_len_en <= 1'b0;
			m_trig   <= 1'b0;
			m_active <= 1'b0;
			m_rdata  <= 8'h00;
			m_lfsr   <= '1;
			m_vol    <= 4'd0;
			m_sample <= 4'd0;
			m_fs_cnt <= 0;
			m_step   <= 0;
			m_len    <= 0;
			m_tmr    <= 0;
			m_div    <= 0;
		end else begin
			if (wr && reg_sel == 2'd1)
				m_env <= env_cfg_t'(wdata);
			if (wr && reg_sel == 2'd2)
				m_poly <= poly_cfg_t'(wdata);
			if (wr && reg_sel == 2'd3)
				m_len_en <= wdata[6];
			m_trig <= wr && (reg_sel == 2'd3) && wdata[7];
			if (rd)
				m_rdata <= (reg_sel == 2'd0) ? 8'hff : (reg_sel == 2'd1) ? m_env :
				           (reg_sel == 2'd2) ? m_poly : {1'b1, m_len_en, 6'h3f};
			m_ticks  <= '0; // Ticks follow the step change by one cycle
			m_fs_cnt <= (m_fs_cnt + 1) % `FS_STEP_CYCLES;
			if (m_fs_cnt == `FS_STEP_CYCLES - 1) begin
				m_step           <= step_n;
				m_ticks.len_tick <= (step_n % 2 == 0);
				m_ticks.env_tick <= (step_n == 7);
			end
			if (wr && reg_sel == 2'd0)
				m_len <= `LEN_MAX - wdata[5:0];
			else if (m_trig && m_len == 0)
				m_len <= `LEN_MAX;
			else if (dec)
				m_len <= m_len - 1;
			if (!dac)
				m_active <= 1'b0;
			else if (m_trig)
				m_active <= 1'b1;
			else if (dec && m_len == 1)
				m_active <= 1'b0;
			if (m_trig) begin
				m_tmr   <= reload;
				m_lfsr  <= '1;
				m_steps <= 0;
			end else if (m_poly.clk_shift < 14 && m_tmr > 1) begin
				m_tmr <= m_tmr - 1;
			end else if (m_poly.clk_shift < 14 && m_tmr == 1) begin
				m_tmr   <= reload;
				m_lfsr  <= shifted;
				m_steps <= m_steps + 1;
			end
			if (m_trig) begin
				m_vol <= m_env.vol_init;
				m_div <= m_env.env_period;
			end else if (m_ticks.env_tick && m_env.env_period != 3'd0) begin
				m_div <= (m_div <= 1) ? m_env.env_period : m_div - 1;
				if (m_div <= 1 && m_env.env_up && m_vol != 4'd15)
					m_vol <= m_vol + 4'd1;
				else if (m_div <= 1 && !m_env.env_up && m_vol != 4'd0)
					m_vol <= m_vol - 4'd1;
			end
			m_sample <= (m_active && !m_lfsr[0]) ? m_vol : 4'd0;
		end
	end

	task automatic check_val(input string name, input logic [7:0] exp, input logic [7:0] act);
		assert (act === exp)
			passes++;
		else begin
			$display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			fails++;
		end
	endtask

	// Outputs are compared with the model before the next inputs go out
	task automatic run_cycle(input logic [1:0] sel, input logic w, input logic r,
	                         input logic [7:0] d);
		@(negedge clk);
		check_val("rdata", m_rdata, rdata);
		check_val("active", m_active, active);
		check_val("sample", m_sample, sample);
		reg_sel = sel;
		wr      = w;
		rd      = r;
		wdata   = d;
	endtask

	task automatic idle(input int n);
		repeat (n) run_cycle(2'd0, 1'b0, 1'b0, 8'h00);
	endtask

	task automatic write_reg(input logic [1:0] sel, input logic [7:0] d);
		run_cycle(sel, 1'b1, 1'b0, d);
		idle(1);
	endtask

	task automatic read_reg(input logic [1:0] sel, input logic [7:0] exp);
		run_cycle(sel, 1'b0, 1'b1, 8'h00);
		idle(1);
		check_val("rdata", exp, rdata);
	endtask

	task automatic end_test(input string name);
		$display("Test %s finished with %0d errors", name, fails - test_fails);
		test_fails = fails;
	endtask

	initial begin
		env_cfg_t env;
		int       shift;
		seed    = 32'hdff6;
		rst_n   = 1'b0;
		reg_sel = 2'd0;
		wr      = 1'b0;
		rd      = 1'b0;
		wdata   = 8'h00;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		idle(2);
		read_reg(2'd0, 8'hff);
		read_reg(2'd1, 8'h00);
		read_reg(2'd2, 8'h00);
		read_reg(2'd3, 8'hbf);
		check_val("active", 1'b0, active);
		check_val("sample", 4'd0, sample);
		end_test("reset state");

		repeat (200)
			run_cycle(2'($random(seed)), 1'($random(seed)), 1'($random(seed)), 8'($random(seed)));
		idle(1);
		end_test("register readback");

		write_reg(2'd1, 8'h00);
		write_reg(2'd3, 8'h80);
		idle(2);
		check_val("active", 1'b0, active);
		write_reg(2'd1, {4'($random(seed)) | 4'd1, 4'($random(seed))});
		write_reg(2'd3, 8'h80);
		idle(1);
		check_val("active", 1'b1, active);
		write_reg(2'd1, 8'h00);
		idle(1);
		check_val("active", 1'b0, active);
		end_test("trigger and DAC");

		for (int i = 0; i < 8; i++) begin
			write_reg(2'd1, 8'hf0); // Full volume with the envelope frozen
			write_reg(2'd0, 8'($random(seed)));
			write_reg(2'd3, (i < 4) ? 8'hc0 : 8'h80);
			idle(2);
			if (i < 4) begin
				while (m_active === 1'b1)
					idle(1);
				check_val("active", 1'b0, active);
			end else begin
				idle(m_len * FRAME / 4 + 64);
				check_val("active", 1'b1, active);
			end
		end
		end_test("length expiry");

		write_reg(2'd1, 8'hf0);
		for (int i = 0; i < 6; i++) begin
			shift = $unsigned($random(seed)) % 3;
			write_reg(2'd2, {shift[3:0], i[0], 3'($random(seed))});
			write_reg(2'd3, 8'h80);
			idle(2);
			while (m_steps < 64)
				idle(1);
		end
		end_test("noise sequence");

		write_reg(2'd2, 8'h00); // Fastest noise clock
		for (int i = 0; i < 3; i++) begin
			env = env_cfg_t'($random(seed));
			env.env_period = 3'($unsigned($random(seed)) % 7 + 1);
			if (env.vol_init == 4'd0)
				env.env_up = 1'b1;
			write_reg(2'd1, env);
			write_reg(2'd3, 8'h80);
			idle((16 * env.env_period + 2) * FRAME);
		end
		end_test("envelope");

		fails = fails + UUT.u_assert.errors;
		$display("Checks passed %0d, failed %0d", passes, fails);
		if (fails == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+src
src/noise_pkg.sv
src/ch4_regs.sv
src/frame_seq.sv
src/ch4_length.sv
src/ch4_noise.sv
src/ch4_volume.sv
src/ch4_top.sv
testbench/ch4_assert.sv
testbench/ch4_tb.sv

// ==== Bender.yml ====
package:
  name: ch4_noise

sources:
  - include_dirs:
      - src
    files:
      - src/noise_pkg.sv
      - src/ch4_regs.sv
      - src/frame_seq.sv
      - src/ch4_length.sv
      - src/ch4_noise.sv
      - src/ch4_volume.sv
      - src/ch4_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/ch4_assert.sv
      - testbench/ch4_tb.sv
